//--- common/soc_map_pkg.sv
package soc_map_pkg;

    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [XLEN-1:0]   data_t;
    typedef logic [XLEN/8-1:0] strb_t;

    // Target selected by the top address nibble
    typedef enum logic [2:0] {
        REGION_NONE = 3'd0,
        REGION_DMEM = 3'd1,
        REGION_BUF0 = 3'd2,
        REGION_BUF1 = 3'd3,
        REGION_PIM  = 3'd4
    } region_e;

    // Region nibble position in the address
    localparam int unsigned REGION_MSB = 31;
    localparam int unsigned REGION_LSB = 28;

    // Byte offset bits below the word index
    localparam int unsigned WORD_LSB = 2;

    // Memory depths in words
    localparam int unsigned DMEM_DEPTH = 1024;
    localparam int unsigned BUF_DEPTH  = 4096;

    localparam int unsigned RST_STAGES = 5;

endpackage

//--- common/soc_bus_pkg.sv
package soc_bus_pkg;

    // APB request from the external master
    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        soc_map_pkg::addr_t  paddr;
        soc_map_pkg::data_t  pwdata;
        soc_map_pkg::strb_t  pstrb;
    } apb_req_t;

    typedef struct packed {
        logic                pready;
        soc_map_pkg::data_t  prdata;
        logic                pslverr;
    } apb_rsp_t;

    // Single-cycle internal memory request
    typedef struct packed {
        logic                valid;
        logic                write;
        soc_map_pkg::addr_t  addr;
        soc_map_pkg::data_t  wdata;
        soc_map_pkg::strb_t  strb;
    } mem_req_t;

    // err follows the current address, not a registered state
    typedef struct packed {
        soc_map_pkg::data_t  rdata;
        logic                err;
    } mem_rsp_t;

endpackage

//--- logic/reset_sync.sv
module reset_sync #(
    parameter int unsigned STAGES = soc_map_pkg::RST_STAGES
) (
    input  logic clk_i,
    input  logic rst_ni,
    output logic sync_rst_no
);

    logic [STAGES-1:0] stage_q;

    // Assert at once, release after STAGES edges
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_q <= '0;
        end else begin
            stage_q <= {stage_q[STAGES-2:0], 1'b1};
        end
    end

    assign sync_rst_no = stage_q[STAGES-1];

endmodule

//--- bus/apb_bridge.sv
module apb_bridge (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  soc_bus_pkg::apb_req_t  apb_req_i,
    output soc_bus_pkg::apb_rsp_t  apb_rsp_o,
    output soc_bus_pkg::mem_req_t  mem_req_o,
    input  soc_bus_pkg::mem_rsp_t  mem_rsp_i
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        READ_WAIT
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   access;

    assign access = apb_req_i.psel && apb_req_i.penable;

    // Payload follows the APB bus, only valid is qualified
    always_comb begin
        mem_req_o.valid = 1'b0;
        mem_req_o.write = apb_req_i.pwrite;
        mem_req_o.addr  = apb_req_i.paddr;
        mem_req_o.wdata = apb_req_i.pwdata;
        mem_req_o.strb  = apb_req_i.pstrb;
        apb_rsp_o       = '0;
        state_d         = state_q;

        unique case (state_q)
            IDLE: begin
                if (apb_req_i.psel && !apb_req_i.penable) begin
                    state_d = ACCESS;
                end
            end
            ACCESS: begin
                if (access) begin
                    // One request per transfer
                    mem_req_o.valid = 1'b1;
                    if (mem_rsp_i.err) begin
                        apb_rsp_o.pready  = 1'b1;
                        apb_rsp_o.pslverr = 1'b1;
                        state_d           = IDLE;
                    end else if (apb_req_i.pwrite) begin
                        apb_rsp_o.pready = 1'b1;
                        state_d          = IDLE;
                    end else begin
                        state_d = READ_WAIT;
                    end
                end else if (!apb_req_i.psel) begin
                    state_d = IDLE;
                end
            end
            READ_WAIT: begin
                // SRAM word arrives one cycle after the request
                apb_rsp_o.pready = 1'b1;
                apb_rsp_o.prdata = mem_rsp_i.rdata;
                state_d          = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- bus/bus_decode.sv
module bus_decode (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  soc_bus_pkg::mem_req_t  req_i,
    output soc_bus_pkg::mem_rsp_t  rsp_o,
    output soc_bus_pkg::mem_req_t  dmem_req_o,
    output soc_bus_pkg::mem_req_t  buf0_req_o,
    output soc_bus_pkg::mem_req_t  buf1_req_o,
    output soc_bus_pkg::mem_req_t  pim_req_o,
    input  soc_map_pkg::data_t     dmem_rdata_i,
    input  soc_map_pkg::data_t     buf0_rdata_i,
    input  soc_map_pkg::data_t     buf1_rdata_i,
    input  soc_map_pkg::data_t     pim_rdata_i
);

    soc_map_pkg::region_e region;
    soc_map_pkg::region_e rd_region_q;

    // Address map lives here only
    always_comb begin
        unique case (req_i.addr[soc_map_pkg::REGION_MSB:soc_map_pkg::REGION_LSB])
            4'h1:    region = soc_map_pkg::REGION_DMEM;
            4'h2:    region = soc_map_pkg::REGION_BUF0;
            4'h3:    region = soc_map_pkg::REGION_BUF1;
            4'h4:    region = soc_map_pkg::REGION_PIM;
            default: region = soc_map_pkg::REGION_NONE;
        endcase
    end

    always_comb begin
        dmem_req_o       = req_i;
        buf0_req_o       = req_i;
        buf1_req_o       = req_i;
        pim_req_o        = req_i;
        dmem_req_o.valid = req_i.valid && (region == soc_map_pkg::REGION_DMEM);
        buf0_req_o.valid = req_i.valid && (region == soc_map_pkg::REGION_BUF0);
        buf1_req_o.valid = req_i.valid && (region == soc_map_pkg::REGION_BUF1);
        pim_req_o.valid  = req_i.valid && (region == soc_map_pkg::REGION_PIM);
    end

    // Remember which target answers the next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_region_q <= soc_map_pkg::REGION_NONE;
        end else if (req_i.valid && !req_i.write) begin
            rd_region_q <= region;
        end
    end

    always_comb begin
        rsp_o.err = (region == soc_map_pkg::REGION_NONE);
        unique case (rd_region_q)
            soc_map_pkg::REGION_DMEM: rsp_o.rdata = dmem_rdata_i;
            soc_map_pkg::REGION_BUF0: rsp_o.rdata = buf0_rdata_i;
            soc_map_pkg::REGION_BUF1: rsp_o.rdata = buf1_rdata_i;
            soc_map_pkg::REGION_PIM:  rsp_o.rdata = pim_rdata_i;
            default:                  rsp_o.rdata = '0;
        endcase
    end

endmodule

//--- mem/sram_bank.sv
module sram_bank #(
    parameter int unsigned DEPTH = soc_map_pkg::DMEM_DEPTH
) (
    input  logic                   clk_i,
    input  soc_bus_pkg::mem_req_t  req_i,
    output soc_map_pkg::data_t     rdata_o
);

    localparam int unsigned AW = $clog2(DEPTH);

    soc_map_pkg::data_t mem_q [DEPTH];
    logic [AW-1:0]      idx;

    // Upper address bits alias back into the array
    assign idx = req_i.addr[soc_map_pkg::WORD_LSB +: AW];

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            if (req_i.write) begin
                for (int b = 0; b < soc_map_pkg::XLEN / 8; b++) begin
                    if (req_i.strb[b]) begin
                        mem_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem_q[idx];
            end
        end
    end

endmodule

//--- logic/pim_port.sv
module pim_port (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  soc_bus_pkg::mem_req_t  req_i,
    output soc_map_pkg::data_t     rdata_o,
    output soc_map_pkg::addr_t     pim_addr_o,
    output soc_map_pkg::data_t     pim_wr_o,
    input  soc_map_pkg::data_t     pim_rd_i
);

    // Outputs to the PIM controller hold between writes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pim_addr_o <= '0;
            pim_wr_o   <= '0;
        end else if (req_i.valid && req_i.write) begin
            pim_addr_o <= req_i.addr;
            pim_wr_o   <= req_i.wdata;
        end
    end

    // Sample the PIM read word
    always_ff @(posedge clk_i) begin
        if (req_i.valid && !req_i.write) begin
            rdata_o <= pim_rd_i;
        end
    end

endmodule

//--- logic/core_top.sv
module core_top (
    input  logic                   clk_i,
    input  logic                   rv_rst_ni,
    input  logic                   host_rst_ni,
    output logic                   sync_rst_no,
    input  soc_bus_pkg::apb_req_t  apb_req_i,
    output soc_bus_pkg::apb_rsp_t  apb_rsp_o,
    output soc_map_pkg::addr_t     pim_addr_o,
    output soc_map_pkg::data_t     pim_wr_o,
    input  soc_map_pkg::data_t     pim_rd_i
);

    logic sync_host_rst_n;
    logic sync_bus_rst_n;

    soc_bus_pkg::mem_req_t bus_req;
    soc_bus_pkg::mem_rsp_t bus_rsp;
    soc_bus_pkg::mem_req_t dmem_req;
    soc_bus_pkg::mem_req_t buf0_req;
    soc_bus_pkg::mem_req_t buf1_req;
    soc_bus_pkg::mem_req_t pim_req;
    soc_map_pkg::data_t    dmem_rdata;
    soc_map_pkg::data_t    buf0_rdata;
    soc_map_pkg::data_t    buf1_rdata;
    soc_map_pkg::data_t    pim_rdata;

    reset_sync u_rv_rst_sync (
        .clk_i       (clk_i),
        .rst_ni      (rv_rst_ni),
        .sync_rst_no (sync_rst_no)
    );

    reset_sync u_host_rst_sync (
        .clk_i       (clk_i),
        .rst_ni      (host_rst_ni),
        .sync_rst_no (sync_host_rst_n)
    );

    // Bus stays up while either domain is running
    assign sync_bus_rst_n = sync_rst_no || sync_host_rst_n;

    apb_bridge u_apb_bridge (
        .clk_i     (clk_i),
        .rst_ni    (sync_bus_rst_n),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .mem_req_o (bus_req),
        .mem_rsp_i (bus_rsp)
    );

    bus_decode u_bus_decode (
        .clk_i        (clk_i),
        .rst_ni       (sync_bus_rst_n),
        .req_i        (bus_req),
        .rsp_o        (bus_rsp),
        .dmem_req_o   (dmem_req),
        .buf0_req_o   (buf0_req),
        .buf1_req_o   (buf1_req),
        .pim_req_o    (pim_req),
        .dmem_rdata_i (dmem_rdata),
        .buf0_rdata_i (buf0_rdata),
        .buf1_rdata_i (buf1_rdata),
        .pim_rdata_i  (pim_rdata)
    );

    sram_bank #(.DEPTH(soc_map_pkg::DMEM_DEPTH)) u_dmem (
        .clk_i   (clk_i),
        .req_i   (dmem_req),
        .rdata_o (dmem_rdata)
    );

    sram_bank #(.DEPTH(soc_map_pkg::BUF_DEPTH)) u_buf0 (
        .clk_i   (clk_i),
        .req_i   (buf0_req),
        .rdata_o (buf0_rdata)
    );

    sram_bank #(.DEPTH(soc_map_pkg::BUF_DEPTH)) u_buf1 (
        .clk_i   (clk_i),
        .req_i   (buf1_req),
        .rdata_o (buf1_rdata)
    );

    pim_port u_pim_port (
        .clk_i      (clk_i),
        .rst_ni     (sync_bus_rst_n),
        .req_i      (pim_req),
        .rdata_o    (pim_rdata),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o),
        .pim_rd_i   (pim_rd_i)
    );

endmodule

//--- dv/core_top_checker.sv
module core_top_checker (
    input logic                  clk_i,
    input logic                  rv_rst_ni,
    input logic                  sync_rst_ni,
    input soc_bus_pkg::apb_req_t apb_req_i,
    input soc_bus_pkg::apb_rsp_t apb_rsp_i
);

    // Completion only inside an APB access phase
    a_pready_in_access: assert property (@(posedge clk_i)
        apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable))
        else $error("pready raised outside an APB access phase");

    a_slverr_with_ready: assert property (@(posedge clk_i)
        apb_rsp_i.pslverr |-> apb_rsp_i.pready)
        else $error("pslverr raised without pready");

    // Core reset asserts with no clock delay
    a_sync_follows_rv: assert property (@(posedge clk_i)
        !rv_rst_ni |-> !sync_rst_ni)
        else $error("sync_rst_no high while rv_rst_ni is low");

    a_err_data_zero: assert property (@(posedge clk_i)
        apb_rsp_i.pslverr |-> (apb_rsp_i.prdata == '0))
        else $error("prdata not zero on an error response");

endmodule

//--- dv/tb_core_top.sv
module tb_core_top;

    localparam int TIMEOUT = 50;

    logic                  clk_i;
    logic                  rv_rst_ni;
    logic                  host_rst_ni;
    logic                  sync_rst_no;
    soc_bus_pkg::apb_req_t apb_req;
    soc_bus_pkg::apb_rsp_t apb_rsp;
    soc_map_pkg::addr_t    pim_addr;
    soc_map_pkg::data_t    pim_wr;
    soc_map_pkg::data_t    pim_rd;

    logic [15:0]        lfsr_q;
    soc_map_pkg::data_t dmem_model [soc_map_pkg::DMEM_DEPTH];
    soc_map_pkg::data_t buf0_model [soc_map_pkg::BUF_DEPTH];
    soc_map_pkg::data_t buf1_model [soc_map_pkg::BUF_DEPTH];
    soc_map_pkg::addr_t pim_addr_model;
    soc_map_pkg::data_t pim_wr_model;
    soc_map_pkg::addr_t dmem_addrs [16];

    core_top u_core_top (
        .clk_i       (clk_i),
        .rv_rst_ni   (rv_rst_ni),
        .host_rst_ni (host_rst_ni),
        .sync_rst_no (sync_rst_no),
        .apb_req_i   (apb_req),
        .apb_rsp_o   (apb_rsp),
        .pim_addr_o  (pim_addr),
        .pim_wr_o    (pim_wr),
        .pim_rd_i    (pim_rd)
    );

    bind core_top core_top_checker u_core_top_checker (
        .clk_i       (clk_i),
        .rv_rst_ni   (rv_rst_ni),
        .sync_rst_ni (sync_rst_no),
        .apb_req_i   (apb_req_i),
        .apb_rsp_i   (apb_rsp_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_data(input soc_map_pkg::data_t got, input soc_map_pkg::data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input soc_map_pkg::addr_t got, input soc_map_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int unsigned word_idx(input soc_map_pkg::addr_t a, input int unsigned depth);
        return (a >> 2) % depth;
    endfunction

    task automatic model_write(input soc_map_pkg::addr_t a, input soc_map_pkg::data_t d,
                               input soc_map_pkg::strb_t s);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                case (a[31:28])
                    4'h1: dmem_model[word_idx(a, soc_map_pkg::DMEM_DEPTH)][b*8 +: 8] = d[b*8 +: 8];
                    4'h2: buf0_model[word_idx(a, soc_map_pkg::BUF_DEPTH)][b*8 +: 8] = d[b*8 +: 8];
                    4'h3: buf1_model[word_idx(a, soc_map_pkg::BUF_DEPTH)][b*8 +: 8] = d[b*8 +: 8];
                    default: ;
                endcase
            end
        end
        // PIM port takes the whole word
        if (a[31:28] == 4'h4) begin
            pim_addr_model = a;
            pim_wr_model   = d;
        end
    endtask

    function automatic soc_map_pkg::data_t model_read(input soc_map_pkg::addr_t a);
        case (a[31:28])
            4'h1:    return dmem_model[word_idx(a, soc_map_pkg::DMEM_DEPTH)];
            4'h2:    return buf0_model[word_idx(a, soc_map_pkg::BUF_DEPTH)];
            4'h3:    return buf1_model[word_idx(a, soc_map_pkg::BUF_DEPTH)];
            4'h4:    return pim_rd;
            default: return '0;
        endcase
    endfunction

    // One APB transfer, checked against the model
    task automatic bus_access(input logic write, input soc_map_pkg::addr_t a,
                              input soc_map_pkg::data_t d, input soc_map_pkg::strb_t s);
        soc_map_pkg::data_t exp;
        int                 waits;
        logic               exp_err;
        exp_err = (a[31:28] == 4'h0) || (a[31:28] > 4'h4);
        exp     = (write || exp_err) ? '0 : model_read(a);
        @(posedge clk_i);
        #2;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: a, pwdata: d, pstrb: s};
        @(posedge clk_i);
        #2;
        apb_req.penable = 1'b1;
        waits = 0;
        @(negedge clk_i);
        while (apb_rsp.pready !== 1'b1) begin
            if (waits >= TIMEOUT) begin
                $display("timeout: no pready for the transfer to address %h", a);
                stop_run();
            end else begin
                @(negedge clk_i);
                waits++;
            end
        end
        check_flag(apb_rsp.pslverr, exp_err, $sformatf("pslverr at %h", a));
        check_count(waits, (write || exp_err) ? 0 : 1, $sformatf("wait states at %h", a));
        if (!write || exp_err) begin
            check_data(apb_rsp.prdata, exp, $sformatf("prdata at %h", a));
        end
        if (write) begin
            model_write(a, d, s);
        end
        @(posedge clk_i);
        #2;
        apb_req = '0;
    endtask

    task automatic release_resets();
        int edges;
        @(posedge clk_i);
        #2;
        rv_rst_ni   = 1'b1;
        host_rst_ni = 1'b1;
        edges = 0;
        while (sync_rst_no !== 1'b1) begin
            if (edges >= TIMEOUT) begin
                $display("timeout: sync_rst_no never released");
                stop_run();
            end else begin
                @(posedge clk_i);
                #1;
                edges++;
            end
        end
        check_count(edges, soc_map_pkg::RST_STAGES, "edges to sync_rst_no release");
    endtask

    task automatic check_pim();
        @(negedge clk_i);
        check_addr(pim_addr, pim_addr_model, "pim_addr_o");
        check_data(pim_wr, pim_wr_model, "pim_wr_o");
    endtask

    initial begin
        soc_map_pkg::addr_t a;
        soc_map_pkg::addr_t off;
        logic [3:0]         nib;
        clk_i          = 1'b0;
        rv_rst_ni      = 1'b1;
        host_rst_ni    = 1'b1;
        apb_req        = '0;
        pim_rd         = '0;
        lfsr_q         = 16'd87;
        pim_addr_model = '0;
        pim_wr_model   = '0;
        #1;
        rv_rst_ni   = 1'b0;
        host_rst_ni = 1'b0;
        repeat (5) begin
            @(negedge clk_i);
            check_flag(sync_rst_no, 1'b0, "sync_rst_no in reset");
        end
        release_resets();
        check_flag(apb_rsp.pready, 1'b0, "pready after reset");
        check_flag(apb_rsp.pslverr, 1'b0, "pslverr after reset");
        check_data(apb_rsp.prdata, '0, "prdata after reset");

        // DMEM traffic, full words first so every byte is known
        for (int i = 0; i < 16; i++) begin
            dmem_addrs[i] = 32'h1000_0000 | (rand_bits(26) << 2);
            bus_access(1'b1, dmem_addrs[i], rand_bits(32), 4'hf);
        end
        repeat (40) begin
            nib = 4'(rand_bits(4));
            bus_access(1'b1, dmem_addrs[nib], rand_bits(32), 4'(rand_bits(4)));
        end
        for (int i = 0; i < 16; i++) begin
            bus_access(1'b0, dmem_addrs[i], '0, '0);
        end

        // Same offset in three memories, then buffer aliasing
        off = rand_bits(10) << 2;
        for (int r = 1; r <= 3; r++) begin
            bus_access(1'b1, (32'(r) << 28) | off, rand_bits(32), 4'hf);
        end
        for (int r = 1; r <= 3; r++) begin
            bus_access(1'b0, (32'(r) << 28) | off, '0, '0);
        end
        for (int r = 2; r <= 3; r++) begin
            a = (32'(r) << 28) | (rand_bits(12) << 2);
            bus_access(1'b1, a, rand_bits(32), 4'hf);
            bus_access(1'b0, a + (rand_bits(2) + 1) * soc_map_pkg::BUF_DEPTH * 4, '0, '0);
        end

        // PIM outputs hold through DMEM traffic
        a = 32'h4000_0000 | rand_bits(28);
        bus_access(1'b1, a, rand_bits(32), 4'hf);
        check_pim();
        bus_access(1'b1, dmem_addrs[0], rand_bits(32), 4'hf);
        bus_access(1'b0, dmem_addrs[0], '0, '0);
        check_pim();
        @(posedge clk_i);
        #2;
        pim_rd = rand_bits(32);
        bus_access(1'b0, a, '0, '0);
        check_pim();

        // Unmapped nibbles
        repeat (8) begin
            nib = 4'(rand_bits(4));
            if (nib >= 4'h1 && nib <= 4'h4) begin
                nib = nib + 4'h4;
            end
            a = {nib, dmem_addrs[nib][27:0]};
            bus_access(1'b1, a, rand_bits(32), 4'hf);
            bus_access(1'b0, a, '0, '0);
            bus_access(1'b0, dmem_addrs[nib], '0, '0);
        end

        // Host domain keeps the bus alive
        @(posedge clk_i);
        #2;
        rv_rst_ni = 1'b0;
        @(negedge clk_i);
        check_flag(sync_rst_no, 1'b0, "sync_rst_no with rv_rst_ni low");
        bus_access(1'b1, dmem_addrs[1], rand_bits(32), 4'(rand_bits(4)));
        bus_access(1'b0, dmem_addrs[1], '0, '0);
        @(posedge clk_i);
        #2;
        host_rst_ni    = 1'b0;
        pim_addr_model = '0;
        pim_wr_model   = '0;
        check_pim();
        repeat (5) @(posedge clk_i);
        release_resets();
        bus_access(1'b0, dmem_addrs[2], '0, '0);

        $display("Regression passed");
        $finish;
    end

endmodule

//--- files.f
common/soc_map_pkg.sv
common/soc_bus_pkg.sv
logic/reset_sync.sv
bus/apb_bridge.sv
bus/bus_decode.sv
mem/sram_bank.sv
logic/pim_port.sv
logic/core_top.sv
dv/core_top_checker.sv
dv/tb_core_top.sv
